// ==== bench/id_stage_assert.sv ====
// flow-control assertions for the decode stage, bound into every id_stage instance
`timescale 1ns/1ps

module id_stage_assert (
  input logic                i_clk,
  input logic                i_rst_n,
  input logic                i_valid,
  input logic                i_es_allowin,
  input logic                i_ds_valid,
  input id_pkg::ds_to_es_t   i_ds_to_es,
  input id_pkg::br_bus_t     i_br_bus
);
  // no output while fetch is told to wait on a load
  a_stall_blocks_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_bus.stall |-> !i_valid) else $error("valid raised during branch stall");

  a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_valid && !i_es_allowin) |=> $stable(i_ds_to_es))
    else $error("decode output changed under back-pressure");

  a_empty_not_taken: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_ds_valid |-> !i_br_bus.taken) else $error("taken raised with empty stage");
endmodule

bind id_stage id_stage_assert u_assert (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_valid      (o_ds_to_es_valid),
  .i_es_allowin (i_es_allowin),
  .i_ds_valid   (ds_valid),
  .i_ds_to_es   (o_ds_to_es),
  .i_br_bus     (o_br_bus)
);

// ==== bench/id_stage_tb.sv ====
// self-checking testbench of the decode stage, random instructions against a reference model
`timescale 1ns/1ps

module id_stage_tb;
  import id_pkg::*;

  localparam int NUM = 400;

  logic i_clk, i_rst_n, i_fs_to_ds_valid, o_ds_allowin, i_es_allowin;
  logic o_ds_to_es_valid, i_es_load_sel;
  fs_to_ds_t i_fs_to_ds;
  ds_to_es_t o_ds_to_es;
  br_bus_t   o_br_bus;
  wb_to_rf_t i_wb_to_rf;
  bypass_t   i_es_bypass, i_ms_bypass, i_ws_bypass;

  xlen_t       shadow [32];
  fs_to_ds_t   held_q [$];  // accepted words not yet taken by execute
  fs_to_ds_t   leaving;
  logic        checking = 1'b0;
  int          leaves = 0;
  logic [31:0] lcg_state = 32'h060acfb5;

  tb_clock_gen u_clk (.o_clk(i_clk), .o_rst_n(i_rst_n));

  id_stage dut (.*);

  function logic [31:0] lcg();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic gpr_addr_t src1_index(inst_t i);
    return (i[6:0] == OPC_LUI) ? 5'd0 : i[19:15];
  endfunction

  function automatic gpr_addr_t src2_index(inst_t i);
    if (i[6:0] == OPC_OP || i[6:0] == OPC_STORE || i[6:0] == OPC_BRANCH) return i[24:20];
    return 5'd0;
  endfunction

  function automatic xlen_t forwarded_operand(gpr_addr_t rs);
    if (rs == 0) return '0;
    if (i_es_bypass.rd == rs) return i_es_bypass.result;
    if (i_ms_bypass.rd == rs) return i_ms_bypass.result;
    if (i_ws_bypass.rd == rs) return i_ws_bypass.result;
    return shadow[rs];
  endfunction

  function automatic logic load_use_stall(inst_t i);
    return i_es_load_sel &&
           (i_es_bypass.rd == src1_index(i) || i_es_bypass.rd == src2_index(i));
  endfunction

  function automatic ds_to_es_t ref_ds_to_es(fs_to_ds_t w);
    ds_to_es_t d;
    inst_t     i;
    i = w.inst;
    d = '0;
    d.pc = w.pc;
    d.rd = i[11:7];
    d.load_sel = (i[6:0] == OPC_LOAD);
    d.ctrl.gpr_wen = 1'b1;
    d.ctrl.src2_imm = 1'b1;
    case (i[6:0])
      OPC_LUI, OPC_AUIPC: begin
        d.imm = {{32{i[31]}}, i[31:12], 12'h000};
        d.ctrl.src1_pc = (i[6:0] == OPC_AUIPC);
      end
      OPC_JAL: begin
        d.imm = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        d.ctrl.src1_pc = 1'b1;
        d.ctrl.jal = 1'b1;
      end
      OPC_JALR: begin
        d.imm = {{52{i[31]}}, i[31:20]};
        d.ctrl.jalr = 1'b1;
      end
      OPC_BRANCH: begin
        d.imm = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        d.ctrl = '0;
        d.ctrl.br_en = 1'b1;
      end
      OPC_LOAD, OPC_STORE: begin
        d.imm = (i[6:0] == OPC_LOAD) ? {{52{i[31]}}, i[31:20]} :
                {{52{i[31]}}, i[31:25], i[11:7]};
        d.ctrl.gpr_wen = (i[6:0] == OPC_LOAD);
        d.ctrl.mem_ren = (i[6:0] == OPC_LOAD);
        d.ctrl.mem_wen = (i[6:0] == OPC_STORE);
        d.ctrl.mem_op = i[14:12];
      end
      OPC_OP_IMM: begin
        d.imm = {{52{i[31]}}, i[31:20]};
        d.ctrl.alu_op = {(i[14:12] == 3'b101) & i[30], i[14:12]};
      end
      OPC_OP: begin
        d.ctrl.src2_imm = 1'b0;
        d.ctrl.alu_op = {i[30], i[14:12]};
      end
      default: begin
        d.ctrl = '0;
        d.ctrl.invalid = 1'b1;
      end
    endcase
    d.rs1_data = forwarded_operand(src1_index(i));
    d.rs2_data = forwarded_operand(src2_index(i));
    return d;
  endfunction

  function automatic br_bus_t ref_br_bus(fs_to_ds_t w);
    ds_to_es_t d;
    br_bus_t   b;
    logic      cond;
    d = ref_ds_to_es(w);
    case (w.inst[14:12])
      3'b000: cond = d.rs1_data == d.rs2_data;
      3'b001: cond = d.rs1_data != d.rs2_data;
      3'b100: cond = $signed(d.rs1_data) < $signed(d.rs2_data);
      3'b101: cond = $signed(d.rs1_data) >= $signed(d.rs2_data);
      3'b110: cond = d.rs1_data < d.rs2_data;
      3'b111: cond = d.rs1_data >= d.rs2_data;
      default: cond = 1'b0;
    endcase
    b.taken = d.ctrl.jal || d.ctrl.jalr || (d.ctrl.br_en && cond);
    b.target = d.ctrl.jalr ? ((d.rs1_data + d.imm) & ~64'h1) : w.pc + d.imm;
    b.stall = b.taken && load_use_stall(w.inst);
    return b;
  endfunction

  task automatic raise_error(input string msg);
    $display("Error %0t: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_ds_to_es(input ds_to_es_t exp, input ds_to_es_t got);
    if (got !== exp) raise_error($sformatf("ds_to_es exp %h got %h", exp, got));
  endtask

  task automatic check_br_bus(input br_bus_t exp, input br_bus_t got);
    if (got !== exp) raise_error($sformatf("br_bus exp %h got %h", exp, got));
  endtask

  task automatic check_flow(input logic exp_valid, input logic exp_allowin);
    if (o_ds_to_es_valid !== exp_valid || o_ds_allowin !== exp_allowin)
      raise_error($sformatf("flow exp valid %b allowin %b got %b %b",
                            exp_valid, exp_allowin, o_ds_to_es_valid, o_ds_allowin));
  endtask

  // compare at every edge and pop before push
  always @(posedge i_clk) begin
    if (checking) begin
      if (held_q.size() == 0) begin
        check_flow(1'b0, 1'b1);
        if (o_br_bus.taken !== 1'b0 || o_br_bus.stall !== 1'b0)
          raise_error("branch bus active with the stage empty");
      end else begin
        check_flow(!load_use_stall(held_q[0].inst),
                   !load_use_stall(held_q[0].inst) && i_es_allowin);
        check_br_bus(ref_br_bus(held_q[0]), o_br_bus);
      end
      if (o_ds_to_es_valid && i_es_allowin && held_q.size() != 0) begin
        leaving = held_q.pop_front();
        check_ds_to_es(ref_ds_to_es(leaving), o_ds_to_es);
        leaves++;
      end
      if (i_fs_to_ds_valid && o_ds_allowin) held_q.push_back(i_fs_to_ds);
    end
  end

  task automatic write_reg(input gpr_addr_t a, input xlen_t d);
    i_wb_to_rf = '{wen: 1'b1, waddr: a, wdata: d};
    @(posedge i_clk);
    #1 i_wb_to_rf.wen = 1'b0;
    if (a != 0) shadow[a] = d;
  endtask

  function automatic gpr_addr_t pick_rd(inst_t i);
    logic [31:0] r;
    r = lcg();
    case (r[1:0])
      2'd0: return 5'd0;
      2'd1: return i[19:15];
      2'd2: return i[24:20];
      default: return r[8:4];
    endcase
  endfunction

  function automatic inst_t rand_inst();
    logic [31:0] r;
    logic [31:0] f;
    logic [6:0]  opc;
    r = lcg();
    case (r[31:28] % 12)
      0: opc = OPC_LUI;
      1: opc = OPC_AUIPC;
      2: opc = OPC_JAL;
      3: opc = OPC_JALR;
      4: opc = OPC_BRANCH;
      5: opc = OPC_LOAD;
      6: opc = OPC_STORE;
      7: opc = OPC_OP_IMM;
      8: opc = OPC_OP;
      9: opc = 7'b0001111;  // illegal here
      10: opc = 7'b1110011;
      default: opc = 7'b0000000;
    endcase
    f = lcg();
    return {f[31:7], opc};
  endfunction

  task automatic run_one(input inst_t inst);
    logic [31:0] r;
    r = lcg();
    i_es_bypass = '{rd: pick_rd(inst), result: {lcg(), lcg()}};
    i_ms_bypass = '{rd: pick_rd(inst), result: {lcg(), lcg()}};
    i_ws_bypass = '{rd: pick_rd(inst), result: {lcg(), lcg()}};
    i_es_load_sel = (r[1:0] == 2'd0);
    if (i_es_load_sel) i_es_bypass.rd = inst[19:15] | 5'd1;
    i_es_allowin = r[2];  // low gives back-pressure
    i_fs_to_ds = '{inst: inst, pc: {lcg(), lcg()} & ~64'h3};
    i_fs_to_ds_valid = 1'b1;
    @(posedge i_clk);
    while (!o_ds_allowin) @(posedge i_clk);
    #1 i_fs_to_ds_valid = 1'b0;
    repeat (r[5:4]) @(posedge i_clk);
    #1 i_es_load_sel = 1'b0;
    i_es_allowin = 1'b1;
    while (held_q.size() != 0) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  initial begin
    logic [31:0] r;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds = '0;
    i_es_allowin = 1'b1;
    i_es_load_sel = 1'b0;
    i_wb_to_rf = '0;
    i_es_bypass = '0;
    i_ms_bypass = '0;
    i_ws_bypass = '0;
    for (int k = 0; k < 32; k++) shadow[k] = '0;
    @(posedge i_clk);
    #1 checking = 1'b1;
    while (!i_rst_n) @(posedge i_clk);
    #1;
    for (int a = 1; a < 32; a++) write_reg(a, {lcg(), lcg()});
    for (int n = 0; n < NUM; n++) begin
      r = lcg();
      if (r[3:0] == 4'd0) write_reg(r[8:4], {lcg(), lcg()});  // x0 included
      run_one(rand_inst());
    end
    if (leaves != NUM) begin
      $display("Error %0t: %0d of %0d words left the stage", $time, leaves, NUM);
      $display(">>> FAIL");
      $fatal(1);
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  // reset, register preload, then twenty cycles per instruction
  initial begin
    #((16 + 31 + NUM * 20) * 10);
    $display("Run did not finish before the watchdog limit");
    $display(">>> FAIL");
    $fatal(1);
  end
endmodule

// ==== bench/tb_clock_gen.sv ====
// testbench clock and reset source, 10 ns clock with active-low reset held for 16 cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst_n
);
  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = !o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (16) @(posedge o_clk);
    #1 o_rst_n = 1'b1;  // released just after the 16th edge
  end
endmodule

// ==== files.f ====
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_gpr_file.sv
rtl/id_operand_bypass.sv
rtl/id_branch_unit.sv
rtl/id_stage.sv
bench/tb_clock_gen.sv
bench/id_stage_assert.sv
bench/id_stage_tb.sv

// ==== rtl/id_branch_unit.sv ====
// branch/jump resolution in decode, drives taken and target of the branch bus to fetch
`timescale 1ns/1ps

module id_branch_unit (
  input  logic             i_valid,
  input  id_pkg::id_ctrl_t i_ctrl,
  input  logic [2:0]       i_funct3,
  input  id_pkg::pc_t      i_pc,
  input  id_pkg::xlen_t    i_imm,
  input  id_pkg::xlen_t    i_rs1_data,
  input  id_pkg::xlen_t    i_rs2_data,
  output logic             o_taken,
  output id_pkg::pc_t      o_target
);
  import id_pkg::*;

  logic eq;
  logic lt;
  logic ltu;
  logic cond;
  pc_t  jalr_sum;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_funct3)
      3'b000:  cond = eq;    // beq
      3'b001:  cond = !eq;   // bne
      3'b100:  cond = lt;    // blt
      3'b101:  cond = !lt;   // bge
      3'b110:  cond = ltu;   // bltu
      3'b111:  cond = !ltu;  // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign o_taken = i_valid && (i_ctrl.jal || i_ctrl.jalr || (i_ctrl.br_en && cond));

  assign jalr_sum = i_rs1_data + i_imm;
  // jalr drops bit 0
  assign o_target = i_ctrl.jalr ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;

endmodule

// ==== rtl/id_decoder.sv ====
// combinational rv64i decoder, instantiated by the decode stage on the held instruction
`timescale 1ns/1ps

module id_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::gpr_addr_t o_rs1,
  output id_pkg::gpr_addr_t o_rs2,
  output id_pkg::gpr_addr_t o_rd,
  output id_pkg::xlen_t     o_imm,
  output id_pkg::id_ctrl_t  o_ctrl,
  output logic              o_load_sel
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign alt    = i_inst[30];  // funct7 bit 5

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  assign o_rd       = i_inst[11:7];
  assign o_load_sel = (opcode == OPC_LOAD);

  always_comb begin
    o_ctrl = '0;
    o_imm  = '0;
    o_rs1  = i_inst[19:15];
    o_rs2  = '0;  // only reported where rs2 is a real source
    case (opcode)
      OPC_LUI: begin
        o_rs1           = '0;  // x0 + imm
        o_imm           = imm_u;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm           = imm_u;
        o_ctrl.src1_pc  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OPC_JAL: begin
        o_imm           = imm_j;
        o_ctrl.src1_pc  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.jal      = 1'b1;
      end
      OPC_JALR: begin
        o_imm           = imm_i;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.jalr     = 1'b1;
      end
      OPC_BRANCH: begin
        o_imm        = imm_b;
        o_rs2        = i_inst[24:20];
        o_ctrl.br_en = 1'b1;
      end
      OPC_LOAD: begin
        o_imm           = imm_i;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.mem_op   = funct3;
      end
      OPC_STORE: begin
        o_imm           = imm_s;
        o_rs2           = i_inst[24:20];
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.mem_wen  = 1'b1;
        o_ctrl.mem_op   = funct3;
      end
      OPC_OP_IMM: begin
        o_imm           = imm_i;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        // srli/srai carry the alternate bit, other immediates do not
        o_ctrl.alu_op   = (funct3 == 3'b101) ? {alt, funct3} : {1'b0, funct3};
      end
      OPC_OP: begin
        o_rs2          = i_inst[24:20];
        o_ctrl.gpr_wen = 1'b1;
        o_ctrl.alu_op  = {alt, funct3};
      end
      default: begin
        o_ctrl.invalid = 1'b1;  // all enables stay clear
      end
    endcase
  end

endmodule

// ==== rtl/id_gpr_file.sv ====
// general register file of the decode stage, two async read ports and the write-back port
`timescale 1ns/1ps

module id_gpr_file (
  input  logic              i_clk,
  input  id_pkg::gpr_addr_t i_raddr1,
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::xlen_t     o_rdata1,
  output id_pkg::xlen_t     o_rdata2,
  input  id_pkg::wb_to_rf_t i_wr
);
  import id_pkg::*;

  xlen_t regs [1:31];  // no storage for x0

  always_ff @(posedge i_clk) begin
    if (i_wr.wen && (i_wr.waddr != '0)) begin
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  // no write-through, a write shows up the cycle after its edge
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== rtl/id_operand_bypass.sv ====
// source operand forwarding from ex/mem/wb and load-use detection for the decode stage
`timescale 1ns/1ps

module id_operand_bypass (
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  id_pkg::xlen_t     i_rf_data1,
  input  id_pkg::xlen_t     i_rf_data2,
  input  id_pkg::bypass_t   i_es,
  input  id_pkg::bypass_t   i_ms,
  input  id_pkg::bypass_t   i_ws,
  input  logic              i_es_load_sel,
  output id_pkg::xlen_t     o_rs1_data,
  output id_pkg::xlen_t     o_rs2_data,
  output logic              o_load_stall
);
  import id_pkg::*;

  // youngest producer wins
  function automatic xlen_t fwd_sel(
    input gpr_addr_t rs,
    input xlen_t     rf_data,
    input bypass_t   es,
    input bypass_t   ms,
    input bypass_t   ws
  );
    return (es.rd != '0 && es.rd == rs) ? es.result :
           (ms.rd != '0 && ms.rd == rs) ? ms.result :
           (ws.rd != '0 && ws.rd == rs) ? ws.result :
                                          rf_data;
  endfunction

  assign o_rs1_data = fwd_sel(i_rs1, i_rf_data1, i_es, i_ms, i_ws);
  assign o_rs2_data = fwd_sel(i_rs2, i_rf_data2, i_es, i_ms, i_ws);

  // load result only exists once it reaches mem
  assign o_load_stall = i_es_load_sel && ((i_es.rd == i_rs1) || (i_es.rd == i_rs2));

endmodule

// ==== rtl/id_pkg.sv ====
// shared widths, opcodes and stage buses of the decode stage, compiled ahead of the rtl
package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;

  // rv64i major opcodes kept by the decoder
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [XLEN-1:0]        pc_t;
  typedef logic [INST_WD-1:0]     inst_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [3:0]             alu_op_t;  // {funct7[5], funct3}
  typedef logic [2:0]             mem_op_t;  // load/store funct3

  typedef struct packed {
    inst_t inst;
    pc_t   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t waddr;
    xlen_t     wdata;
  } wb_to_rf_t;

  // rd of 0 means nothing to forward
  typedef struct packed {
    gpr_addr_t rd;
    xlen_t     result;
  } bypass_t;

  typedef struct packed {
    logic    src1_pc;
    logic    src2_imm;
    alu_op_t alu_op;
    logic    gpr_wen;
    logic    mem_ren;
    logic    mem_wen;
    mem_op_t mem_op;
    logic    br_en;
    logic    jal;
    logic    jalr;
    logic    invalid;
  } id_ctrl_t;

  typedef struct packed {
    logic      load_sel;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;
    pc_t       pc;
    gpr_addr_t rd;
    id_ctrl_t  ctrl;
  } ds_to_es_t;

  typedef struct packed {
    logic stall;
    logic taken;
    pc_t  target;
  } br_bus_t;

endpackage

// ==== rtl/id_stage.sv ====
// decode stage top, holds the fetch word and feeds execute with valid/allowin flow control
`timescale 1ns/1ps

module id_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t i_fs_to_ds,
  output logic              o_ds_allowin,
  input  logic              i_es_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::ds_to_es_t o_ds_to_es,
  output id_pkg::br_bus_t   o_br_bus,
  input  id_pkg::wb_to_rf_t i_wb_to_rf,
  input  logic              i_es_load_sel,
  input  id_pkg::bypass_t   i_es_bypass,
  input  id_pkg::bypass_t   i_ms_bypass,
  input  id_pkg::bypass_t   i_ws_bypass
);
  import id_pkg::*;

  logic      ds_valid;
  logic      ds_ready_go;
  fs_to_ds_t ds_word;
  gpr_addr_t rs1;
  gpr_addr_t rs2;
  gpr_addr_t rd;
  xlen_t     imm;
  id_ctrl_t  ctrl;
  logic      load_sel;
  xlen_t     rf_rdata1;
  xlen_t     rf_rdata2;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  logic      load_stall;
  logic      br_taken;
  pc_t       br_target;

  assign ds_ready_go      = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_word <= i_fs_to_ds;  // held until execute takes it
    end
  end

  id_decoder u_decoder (
    .i_inst     (ds_word.inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_imm      (imm),
    .o_ctrl     (ctrl),
    .o_load_sel (load_sel)
  );

  id_gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_wr     (i_wb_to_rf)
  );

  id_operand_bypass u_bypass (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rf_data1    (rf_rdata1),
    .i_rf_data2    (rf_rdata2),
    .i_es          (i_es_bypass),
    .i_ms          (i_ms_bypass),
    .i_ws          (i_ws_bypass),
    .i_es_load_sel (i_es_load_sel),
    .o_rs1_data    (rs1_data),
    .o_rs2_data    (rs2_data),
    .o_load_stall  (load_stall)
  );

  id_branch_unit u_bru (
    .i_valid    (ds_valid),
    .i_ctrl     (ctrl),
    .i_funct3   (ds_word.inst[14:12]),
    .i_pc       (ds_word.pc),
    .i_imm      (imm),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_taken    (br_taken),
    .o_target   (br_target)
  );

  assign o_ds_to_es = '{
    load_sel: load_sel,
    rs1_data: rs1_data,
    rs2_data: rs2_data,
    imm:      imm,
    pc:       ds_word.pc,
    rd:       rd,
    ctrl:     ctrl
  };

  // stall tells fetch the target rests on a pending load
  assign o_br_bus = '{
    stall:  br_taken & load_stall,
    taken:  br_taken,
    target: br_target
  };

endmodule
